//--- design/clk_synth_params.svh
`ifndef CLK_SYNTH_PARAMS_SVH
`define CLK_SYNTH_PARAMS_SVH

// bank geometry
`define CS_NUM_REGS         8
`define CS_WORD_W           32
`define CS_ADDR_W           4
`define CS_IDX_W            3           // log2 of CS_NUM_REGS
`define CS_CTRL_ADDR        `CS_NUM_REGS // control word sits just past the bank

// power-up words, low nibble is the chip register number
`define CS_DEF_REG0         32'h0002_0000  // soft reset word
`define CS_DEF_REG1         32'h0014_0001
`define CS_DEF_REG2         32'h0014_0302
`define CS_DEF_REG3         32'h8000_0143
`define CS_DEF_REG4         32'h1400_0284
`define CS_DEF_REG5         32'h0040_1005
`define CS_DEF_REG6         32'h1170_0346
`define CS_DEF_REG7         32'h0006_0007

// timing, all in slow_clk cycles
`define CS_STARTUP_WAIT     64
`define CS_DEFAULT_HOLD     4
`define CS_SYNC_LOW_CYCLES  16

`endif

//--- design/clk_synth_pkg.sv
`include "clk_synth_params.svh"

package clk_synth_pkg;

    // one host write, addr + data
    typedef struct packed {
        logic [`CS_ADDR_W-1:0] addr;
        logic [`CS_WORD_W-1:0] data;
    } host_wr_t;

    // word handed to the shifter, idx travels along for tracing
    typedef struct packed {
        logic [`CS_IDX_W-1:0]  idx;
        logic [`CS_WORD_W-1:0] word;
    } synth_word_t;

    //*********************************************************************
    // state encodings
    //*********************************************************************
    typedef enum logic [1:0] {ST_WAIT, ST_LOAD, ST_KICK, ST_DONE} startup_state_e;

    typedef enum logic [2:0] {
        SQ_IDLE, SQ_SEND, SQ_WAIT_ACK, SQ_WAIT_DROP, SQ_NEXT, SQ_SYNC_LOW
    } seq_state_e;

    typedef enum logic [1:0] {SH_IDLE, SH_SHIFT, SH_ACK} shift_state_e;

endpackage

//--- design/synth_reg_bank.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module synth_reg_bank
    import clk_synth_pkg::*;
(
    input  logic                  slow_clk,
    input  logic                  resetS,
    input  logic                  load_defaults, // level from startup_ctrl
    input  host_wr_t              wr,
    input  logic                  wr_req,
    input  logic [`CS_IDX_W-1:0]  rd_idx,
    output logic                  wr_ack,
    output logic [`CS_WORD_W-1:0] rd_word,
    output logic                  host_go        // start bit rising edge
);

    // defaults, index order
    localparam logic [`CS_WORD_W-1:0] DEF_WORDS [`CS_NUM_REGS] = '{
        `CS_DEF_REG0, `CS_DEF_REG1, `CS_DEF_REG2, `CS_DEF_REG3,
        `CS_DEF_REG4, `CS_DEF_REG5, `CS_DEF_REG6, `CS_DEF_REG7
    };

    logic [`CS_WORD_W-1:0] cfg [`CS_NUM_REGS]; // config words
    logic [`CS_WORD_W-1:0] ctrl_word;          // bit 0 = start
    logic                  start_q;            // last start bit
    logic                  wr_take;            // first cycle of a request
    logic                  hit_cfg;
    logic                  hit_ctrl;

    //*********************************************************************
    // host write handshake and address decode
    //*********************************************************************
    assign wr_take  = wr_req && !wr_ack;
    assign hit_cfg  = (wr.addr < `CS_NUM_REGS);
    assign hit_ctrl = (wr.addr == `CS_CTRL_ADDR); // higher addresses just get acked

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            wr_ack <= 1'b0;
        end
        else
        begin
            wr_ack <= wr_req; // rises a cycle after req, falls a cycle after it drops
        end
    end

    // storage, defaults win over any write in flight
    always_ff @(posedge slow_clk)
    begin
        if (resetS || load_defaults)
        begin
            for (int i = 0; i < `CS_NUM_REGS; i++)
            begin
                cfg[i] <= DEF_WORDS[i];
            end
            ctrl_word <= '0;
        end
        else if (wr_take)
        begin
            if (hit_cfg)
                cfg[wr.addr[`CS_IDX_W-1:0]] <= wr.data;
            else if (hit_ctrl)
                ctrl_word <= wr.data;
        end
    end

    //*********************************************************************
    // start bit edge detect
    //*********************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
            start_q <= 1'b0;
        else
            start_q <= ctrl_word[0];
    end

    assign host_go = ctrl_word[0] && !start_q; // 0 -> 1 only, rewriting 1 does nothing

    assign rd_word = cfg[rd_idx]; // combinational read for the sequencer

endmodule

//--- design/startup_ctrl.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module startup_ctrl
    import clk_synth_pkg::*;
(
    input  logic slow_clk,
    input  logic resetS,
    output logic load_defaults, // held for CS_DEFAULT_HOLD cycles
    output logic boot_go        // single pulse, kicks the first run
);

    startup_state_e state;
    logic [15:0]    cnt; // shared by wait and hold

    //*********************************************************************
    // power-up sequence, runs once per reset
    //*********************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state <= ST_WAIT;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_WAIT:
                begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'(`CS_STARTUP_WAIT - 1)) // chip power settles
                    begin
                        cnt   <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD:
                begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'(`CS_DEFAULT_HOLD - 1))
                        state <= ST_KICK;
                end
                ST_KICK: state <= ST_DONE; // one cycle only
                default: state <= ST_DONE; // parked until next reset
            endcase
        end
    end

    assign load_defaults = (state == ST_LOAD);
    assign boot_go       = (state == ST_KICK); // first cycle after the load drops

endmodule

//--- design/program_sequencer.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module program_sequencer
    import clk_synth_pkg::*;
(
    input  logic                  slow_clk,
    input  logic                  resetS,
    input  logic                  host_go,
    input  logic                  boot_go,
    input  logic [`CS_WORD_W-1:0] rd_word,
    input  logic                  shift_ack,
    output logic [`CS_IDX_W-1:0]  rd_idx,
    output synth_word_t           word_out,
    output logic                  shift_req,
    output logic                  sync
);

    seq_state_e           state;
    logic [`CS_IDX_W-1:0] idx;      // word being sent
    logic [7:0]           sync_cnt; // sync low length
    logic                 last_word;

    assign rd_idx    = idx;
    assign last_word = (idx == `CS_IDX_W'(`CS_NUM_REGS - 1));

    //*********************************************************************
    // run control, one word per req/ack round
    //*********************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= SQ_IDLE;
            idx       <= '0;
            shift_req <= 1'b0;
            sync      <= 1'b1;
            sync_cnt  <= '0;
        end
        else
        begin
            case (state)
                SQ_IDLE:
                begin
                    if (host_go || boot_go) // go strobes only seen here
                    begin
                        idx   <= '0;
                        state <= SQ_SEND;
                    end
                end
                SQ_SEND:
                begin
                    shift_req <= 1'b1; // word_out latched below on this edge
                    state     <= SQ_WAIT_ACK;
                end
                SQ_WAIT_ACK:
                begin
                    if (shift_ack)
                    begin
                        shift_req <= 1'b0;
                        state     <= SQ_WAIT_DROP;
                    end
                end
                SQ_WAIT_DROP:
                begin
                    if (!shift_ack)
                    begin
                        if (last_word)
                        begin
                            sync     <= 1'b0; // chip resyncs its outputs
                            sync_cnt <= '0;
                            state    <= SQ_SYNC_LOW;
                        end
                        else
                            state <= SQ_NEXT;
                    end
                end
                SQ_NEXT:
                begin
                    idx   <= idx + `CS_IDX_W'(1);
                    state <= SQ_SEND;
                end
                SQ_SYNC_LOW:
                begin
                    sync_cnt <= sync_cnt + 8'd1;
                    if (sync_cnt == 8'(`CS_SYNC_LOW_CYCLES - 1))
                    begin
                        sync  <= 1'b1;
                        state <= SQ_IDLE;
                    end
                end
                default: state <= SQ_IDLE;
            endcase
        end
    end

    // payload, grabbed when the request goes out
    always_ff @(posedge slow_clk)
    begin
        if (state == SQ_SEND)
            word_out <= '{idx: idx, word: rd_word};
    end

endmodule

//--- design/serial_shifter.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module serial_shifter
    import clk_synth_pkg::*;
(
    input  logic        slow_clk,
    input  logic        resetS,
    input  synth_word_t word_in,
    input  logic        shift_req,
    output logic        shift_ack,
    output logic        ddat,
    output logic        dlen   // low while a word is on the wire
);

    shift_state_e          state;
    logic [`CS_WORD_W-1:0] sreg;    // msb goes out first
    logic [4:0]            bit_cnt; // bits already shifted

    assign ddat = sreg[`CS_WORD_W-1];

    //*********************************************************************
    // word framing, 32 bits under dlen low
    //*********************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= SH_IDLE;
            sreg      <= '0;       // keeps ddat low after reset
            bit_cnt   <= '0;
            dlen      <= 1'b1;
            shift_ack <= 1'b0;
        end
        else
        begin
            case (state)
                SH_IDLE:
                begin
                    if (shift_req)
                    begin
                        sreg    <= word_in.word; // bit 31 on the wire now
                        bit_cnt <= '0;
                        dlen    <= 1'b0;
                        state   <= SH_SHIFT;
                    end
                end
                SH_SHIFT:
                begin
                    sreg    <= {sreg[`CS_WORD_W-2:0], 1'b0};
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd31)
                    begin
                        dlen      <= 1'b1; // chip latches the word
                        shift_ack <= 1'b1;
                        state     <= SH_ACK;
                    end
                end
                SH_ACK:
                begin
                    if (!shift_req) // close the four-phase round
                    begin
                        shift_ack <= 1'b0;
                        state     <= SH_IDLE;
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

endmodule

//--- design/clk_synth_top.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module clk_synth_top (
    input  logic                    slow_clk,
    input  logic                    resetS,
    input  clk_synth_pkg::host_wr_t wr,
    input  logic                    wr_req,
    output logic                    wr_ack,
    output logic                    dclk,
    output logic                    ddat,
    output logic                    dlen,
    output logic                    sync
);

    logic                       load_defaults;
    logic                       boot_go;
    logic                       host_go;
    logic [`CS_IDX_W-1:0]       rd_idx;
    logic [`CS_WORD_W-1:0]      rd_word;
    clk_synth_pkg::synth_word_t word_out;
    logic                       shift_req;
    logic                       shift_ack;

    assign dclk = ~slow_clk; // chip samples on our falling edge

    //*********************************************************************
    // blocks
    //*********************************************************************
    synth_reg_bank bank_i (.slow_clk, .resetS, .load_defaults, .wr, .wr_req, .rd_idx,
                           .wr_ack, .rd_word, .host_go);

    startup_ctrl startup_i (.slow_clk, .resetS, .load_defaults, .boot_go);

    program_sequencer seq_i (.slow_clk, .resetS, .host_go, .boot_go, .rd_word, .shift_ack,
                             .rd_idx, .word_out, .shift_req, .sync);

    serial_shifter shifter_i (.slow_clk, .resetS, .word_in(word_out), .shift_req,
                              .shift_ack, .ddat, .dlen);

endmodule

//--- verification/tb_synth_monitor.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module tb_synth_monitor (
    input logic slow_clk,
    input logic ddat,
    input logic dlen,
    input logic sync
);

    logic [`CS_WORD_W-1:0] frames [$];     // finished frames, oldest first
    int                    sync_lens [$];  // low length of each sync pulse
    logic [`CS_WORD_W-1:0] sh      = '0;   // frame being assembled
    int                    nbits   = 0;
    int                    low_cnt = 0;

    // chip view, data taken on the dclk rising edge
    always @(negedge slow_clk)
    begin
        if (!dlen)
        begin
            sh = {sh[`CS_WORD_W-2:0], ddat}; // msb arrives first
            nbits++;
        end
        if (nbits == `CS_WORD_W || (dlen && nbits != 0)) // short frames kept too
        begin
            frames.push_back(sh);
            nbits = 0;
        end
        if (!sync)
            low_cnt++;
        else if (low_cnt != 0)
        begin
            sync_lens.push_back(low_cnt); // pulse just ended
            low_cnt = 0;
        end
    end

endmodule

//--- verification/tb_clk_synth.sv
`timescale 1ns/1ps
`include "clk_synth_params.svh"

module tb_clk_synth
    import clk_synth_pkg::*;
();

    // 4 runs, startup wait and reset, plus slack
    localparam int WDOG_CYCLES = 4 * (`CS_NUM_REGS * 40 + `CS_SYNC_LOW_CYCLES)
                                 + `CS_STARTUP_WAIT + `CS_DEFAULT_HOLD + 5 + 2000;
    localparam logic [`CS_ADDR_W-1:0] CTRL_ADDR = `CS_ADDR_W'(`CS_CTRL_ADDR);

    logic     slow_clk = 1'b0;
    logic     resetS   = 1'b1;
    host_wr_t wr       = '0;
    logic     wr_req   = 1'b0;
    logic     wr_ack, dclk, ddat, dlen, sync;

    // expected bank contents
    logic [`CS_WORD_W-1:0] model [`CS_NUM_REGS] = '{
        `CS_DEF_REG0, `CS_DEF_REG1, `CS_DEF_REG2, `CS_DEF_REG3,
        `CS_DEF_REG4, `CS_DEF_REG5, `CS_DEF_REG6, `CS_DEF_REG7
    };
    logic [31:0] seed        = 32'd27;
    int          errors      = 0;
    int          checks      = 0;
    int          frames_seen = 0; // frames already compared
    int          syncs_seen  = 0;

    always #50 slow_clk = ~slow_clk; // 100 ns period

    clk_synth_top clk_synth_top_i (.*);
    tb_synth_monitor mon_i (.slow_clk, .ddat, .dlen, .sync);

    //*********************************************************************
    // helpers
    //*********************************************************************
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // dclk is slow_clk inverted, looked at mid-phase away from the edges
    task automatic check_dclk();
        #25;
        check_value("dclk low phase", 1, 32'(dclk));
        @(posedge slow_clk);
        #25;
        check_value("dclk high phase", 0, 32'(dclk));
        @(negedge slow_clk);
    endtask

    // full four-phase round, ack edges one cycle after req edges
    task automatic host_write(input logic [`CS_ADDR_W-1:0] addr, input logic [31:0] data);
        wr.addr = addr;
        wr.data = data;
        wr_req  = 1'b1;
        @(negedge slow_clk);
        check_value("wr_ack rise", 1, 32'(wr_ack));
        while (!wr_ack)
            @(negedge slow_clk);
        wr_req = 1'b0;
        @(negedge slow_clk);
        check_value("wr_ack fall", 0, 32'(wr_ack));
        while (wr_ack)
            @(negedge slow_clk);
        if (addr < `CS_ADDR_W'(`CS_NUM_REGS))
            model[addr[`CS_IDX_W-1:0]] = data; // higher addresses are dropped
    endtask

    // waits for the sync pulse that closes a run, then compares its frames
    task automatic expect_run(input string name);
        int first;
        first = frames_seen;
        while (mon_i.sync_lens.size() <= syncs_seen)
            @(posedge slow_clk);
        check_value({name, " frames"}, `CS_NUM_REGS, mon_i.frames.size() - first);
        for (int i = 0; i < `CS_NUM_REGS && first + i < mon_i.frames.size(); i++)
            check_value($sformatf("%s word %0d", name, i), model[i[`CS_IDX_W-1:0]],
                        mon_i.frames[first + i]);
        check_value({name, " sync"}, `CS_SYNC_LOW_CYCLES, mon_i.sync_lens[syncs_seen]);
        frames_seen = mon_i.frames.size();
        syncs_seen++;
        @(negedge slow_clk);
    endtask

    initial
    begin
        repeat (WDOG_CYCLES) @(posedge slow_clk);
        $display("watchdog expired after %0d cycles, a run never finished", WDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    //*********************************************************************
    // tests
    //*********************************************************************
    initial
    begin
        logic [31:0] r;
        repeat (5) @(negedge slow_clk);
        resetS = 1'b0;
        check_value("reset dlen", 1, 32'(dlen)); // quiet pins before startup
        check_value("reset sync", 1, 32'(sync));
        check_value("reset wr_ack", 0, 32'(wr_ack));
        check_value("reset ddat", 0, 32'(ddat));
        check_dclk();
        expect_run("startup run");
        repeat (12)
        begin
            r = next_random();
            host_write({1'b0, r[18:16]}, next_random());
        end
        host_write(CTRL_ADDR, 32'd1);
        expect_run("host run");
        host_write(CTRL_ADDR, 32'd1); // bit already set, no edge
        repeat (`CS_NUM_REGS * 40) @(posedge slow_clk);
        check_value("rewrite frames", frames_seen, mon_i.frames.size());
        check_value("rewrite syncs", syncs_seen, mon_i.sync_lens.size());
        @(negedge slow_clk);
        host_write(CTRL_ADDR, 32'd0);
        host_write(CTRL_ADDR, 32'd1);
        expect_run("rerun");
        r = next_random();
        host_write((r[3:0] > CTRL_ADDR) ? r[3:0] : 4'hf, next_random());
        host_write(CTRL_ADDR, 32'd0);
        host_write(CTRL_ADDR, 32'd1);
        expect_run("bad address run"); // model untouched by the stray write
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- clk_synth_top.f
+incdir+design
design/clk_synth_pkg.sv
design/synth_reg_bank.sv
design/startup_ctrl.sv
design/program_sequencer.sv
design/serial_shifter.sv
design/clk_synth_top.sv
verification/tb_synth_monitor.sv
verification/tb_clk_synth.sv

//--- Makefile
# build and run the clock synthesizer testbench with verilator
VERILATOR ?= verilator
TOP       ?= tb_clk_synth
FILELIST  ?= clk_synth_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
